//--- Bender.yml
package:
  name: mmu_xlate

sources:
  - logic/mmu_pkg.sv
  - logic/csr_pkg.sv
  - logic/tlb_search_if.sv
  - logic/tlb.sv
  - logic/addr_translate.sv
  - logic/mmu_csr_axil.sv
  - logic/mmu_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/mmu_tb.sv

//--- list.f
logic/mmu_pkg.sv
logic/csr_pkg.sv
logic/tlb_search_if.sv
logic/tlb.sv
logic/addr_translate.sv
logic/mmu_csr_axil.sv
logic/mmu_top.sv
test/tb_clock.sv
test/mmu_tb.sv

//--- logic/addr_translate.sv
`timescale 1ns/10ps

module addr_translate
    import mmu_pkg::*;
    import csr_pkg::*;
(
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             req_valid,
    input  logic [31:0]      va,
    input  access_t          access,
    output logic             rsp_valid,
    output logic [palen-1:0] pa,
    output tlb_ex_t          tlb_ex,
    input  logic [31:0]      crmd,
    input  logic [31:0]      asid,
    input  logic [31:0]      dmw0,
    input  logic [31:0]      dmw1,
    tlb_search_if.requester  search
);
    plv_t             cur_plv;
    logic             direct;
    logic             dmw_hit0;
    logic             dmw_hit1;
    logic             mapped;
    logic             valid_hit;
    logic [palen-1:0] pa_d;
    tlb_ex_t          ex_d;

    assign cur_plv  = crmd[crmd_plv_lo +: 2];
    assign direct   = crmd[crmd_da] & ~crmd[crmd_pg];
    assign dmw_hit0 = dmw0[cur_plv] & (dmw0[dmw_vseg_lo +: 3] == va[31:29]);
    assign dmw_hit1 = dmw1[cur_plv] & (dmw1[dmw_vseg_lo +: 3] == va[31:29]);
    assign mapped   = ~direct & ~dmw_hit0 & ~dmw_hit1;

    assign search.vppn     = va[31:13];
    assign search.va_bit12 = va[12];
    assign search.asid     = asid[asid_lo +: 10];

    assign valid_hit = search.found & search.v;

    always_comb begin
        if (direct) begin
            pa_d = va;
        end else if (dmw_hit0) begin
            pa_d = {dmw0[dmw_pseg_lo +: 3], va[28:0]};
        end else if (dmw_hit1) begin
            pa_d = {dmw1[dmw_pseg_lo +: 3], va[28:0]};
        end else if (search.ps == ps_4k) begin
            pa_d = {search.ppn, va[11:0]};
        end else begin
            pa_d = {search.ppn[19:10], va[21:0]};
        end
    end

    // flags only for tlb-mapped addresses
    always_comb begin
        ex_d = '0;
        if (mapped) begin
            ex_d.tlbr = ~search.found;
            if (search.found && !search.v) begin
                case (access)
                    acc_fetch: ex_d.pif = 1'b1;
                    acc_load:  ex_d.pil = 1'b1;
                    default:   ex_d.pis = 1'b1;
                endcase
            end
            ex_d.ppe = valid_hit & (cur_plv > search.plv);
            ex_d.pme = valid_hit & (access == acc_store) & (cur_plv <= search.plv) & ~search.d;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid) begin
            pa     <= pa_d;
            tlb_ex <= ex_d;
        end
    end

endmodule

//--- logic/csr_pkg.sv
package csr_pkg;

    localparam logic [7:0] reg_crmd    = 8'h00;
    localparam logic [7:0] reg_asid    = 8'h04;
    localparam logic [7:0] reg_dmw0    = 8'h08;
    localparam logic [7:0] reg_dmw1    = 8'h0C;
    localparam logic [7:0] reg_tlbidx  = 8'h10;
    localparam logic [7:0] reg_tlbehi  = 8'h14;
    localparam logic [7:0] reg_tlbelo0 = 8'h18;
    localparam logic [7:0] reg_tlbelo1 = 8'h1C;
    localparam logic [7:0] reg_tlbcmd  = 8'h20;

    localparam int crmd_plv_lo = 0;
    localparam int crmd_da     = 3;
    localparam int crmd_pg     = 4;

    // dmw plv enables sit at bits 3:0, indexed by plv
    localparam int dmw_pseg_lo = 25;
    localparam int dmw_vseg_lo = 29;

    localparam int tlbidx_ps_lo = 24;
    localparam int tlbidx_ne    = 31;

    localparam int tlbehi_vppn_lo = 13;

    localparam int tlbelo_v      = 0;
    localparam int tlbelo_d      = 1;
    localparam int tlbelo_plv_lo = 2;
    localparam int tlbelo_mat_lo = 4;
    localparam int tlbelo_g      = 6;
    localparam int tlbelo_ppn_lo = 8;

    localparam int asid_lo = 0;

    localparam int   cmd_bit    = 0;
    localparam int   cmd_op_lo  = 4;
    localparam logic cmd_tlbwr  = 1'b0;
    localparam logic cmd_invtlb = 1'b1;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- logic/mmu_csr_axil.sv
`timescale 1ns/10ps

module mmu_csr_axil
    import mmu_pkg::*;
    import csr_pkg::*;
#(
    parameter int TLBNUM = tlb_num
)
(
    input  logic                      aclk,
    input  logic                      arst_n,
    input  logic [7:0]                s_awaddr,
    input  logic                      s_awvalid,
    output logic                      s_awready,
    input  logic [31:0]               s_wdata,
    input  logic [3:0]                s_wstrb,
    input  logic                      s_wvalid,
    output logic                      s_wready,
    output logic [1:0]                s_bresp,
    output logic                      s_bvalid,
    input  logic                      s_bready,
    input  logic [7:0]                s_araddr,
    input  logic                      s_arvalid,
    output logic                      s_arready,
    output logic [31:0]               s_rdata,
    output logic [1:0]                s_rresp,
    output logic                      s_rvalid,
    input  logic                      s_rready,
    output logic [31:0]               crmd,
    output logic [31:0]               asid,
    output logic [31:0]               dmw0,
    output logic [31:0]               dmw1,
    output logic                      tlb_we,
    output logic [$clog2(TLBNUM)-1:0] tlb_windex,
    output tlb_entry_t                tlb_wentry,
    output logic                      inv_valid,
    output logic [4:0]                inv_op
);
    localparam int idx_w = $clog2(TLBNUM);

    logic [31:0] tlbidx;
    logic [31:0] tlbehi;
    logic [31:0] tlbelo0;
    logic [31:0] tlbelo1;
    logic        wr_fire;
    logic        rd_fire;
    logic        is_cmd;
    logic [31:0] rd_val;
    logic        rd_ok;

    assign wr_fire = s_awvalid & s_awready & s_wvalid & s_wready;
    assign rd_fire = s_arvalid & s_arready;
    assign is_cmd  = wr_fire & (s_awaddr == reg_tlbcmd);

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                          input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic tlb_page_t page_of(input logic [31:0] lo);
        tlb_page_t pg;
        pg.ppn = lo[tlbelo_ppn_lo +: 20];
        pg.plv = lo[tlbelo_plv_lo +: 2];
        pg.mat = lo[tlbelo_mat_lo +: 2];
        pg.d   = lo[tlbelo_d];
        pg.v   = lo[tlbelo_v];
        return pg;
    endfunction

    // write channel, address and data accepted together
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            s_bvalid  <= 1'b0;
            s_bresp   <= resp_okay;
            crmd      <= 32'h0000_0008;
            asid      <= '0;
            dmw0      <= '0;
            dmw1      <= '0;
            tlbidx    <= '0;
            tlbehi    <= '0;
            tlbelo0   <= '0;
            tlbelo1   <= '0;
        end else begin
            s_awready <= s_awvalid & s_wvalid & ~s_bvalid & ~s_awready;
            s_wready  <= s_awvalid & s_wvalid & ~s_bvalid & ~s_awready;
            if (s_bvalid && s_bready) begin
                s_bvalid <= 1'b0;
            end
            if (wr_fire) begin
                s_bvalid <= 1'b1;
                s_bresp  <= resp_okay;
                case (s_awaddr)
                    reg_crmd:    crmd    <= merge(crmd, s_wdata, s_wstrb);
                    reg_asid:    asid    <= merge(asid, s_wdata, s_wstrb);
                    reg_dmw0:    dmw0    <= merge(dmw0, s_wdata, s_wstrb);
                    reg_dmw1:    dmw1    <= merge(dmw1, s_wdata, s_wstrb);
                    reg_tlbidx:  tlbidx  <= merge(tlbidx, s_wdata, s_wstrb);
                    reg_tlbehi:  tlbehi  <= merge(tlbehi, s_wdata, s_wstrb);
                    reg_tlbelo0: tlbelo0 <= merge(tlbelo0, s_wdata, s_wstrb);
                    reg_tlbelo1: tlbelo1 <= merge(tlbelo1, s_wdata, s_wstrb);
                    reg_tlbcmd:  ;
                    default:     s_bresp <= resp_slverr;
                endcase
            end
        end
    end

    // command pulses line up with the first bvalid cycle
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            tlb_we    <= 1'b0;
            inv_valid <= 1'b0;
        end else begin
            tlb_we    <= is_cmd & (s_wdata[cmd_bit] == cmd_tlbwr);
            inv_valid <= is_cmd & (s_wdata[cmd_bit] == cmd_invtlb);
        end
    end

    always_ff @(posedge aclk) begin
        if (is_cmd) begin
            inv_op           <= s_wdata[cmd_op_lo +: 5];
            tlb_windex       <= idx_w'(tlbidx % TLBNUM);
            tlb_wentry.e     <= ~tlbidx[tlbidx_ne];
            tlb_wentry.vppn  <= tlbehi[tlbehi_vppn_lo +: 19];
            tlb_wentry.ps    <= tlbidx[tlbidx_ps_lo +: 6];
            tlb_wentry.asid  <= asid[asid_lo +: 10];
            tlb_wentry.g     <= tlbelo0[tlbelo_g] & tlbelo1[tlbelo_g];
            tlb_wentry.page0 <= page_of(tlbelo0);
            tlb_wentry.page1 <= page_of(tlbelo1);
        end
    end

    always_comb begin
        rd_ok = 1'b1;
        case (s_araddr)
            reg_crmd:    rd_val = crmd;
            reg_asid:    rd_val = asid;
            reg_dmw0:    rd_val = dmw0;
            reg_dmw1:    rd_val = dmw1;
            reg_tlbidx:  rd_val = tlbidx;
            reg_tlbehi:  rd_val = tlbehi;
            reg_tlbelo0: rd_val = tlbelo0;
            reg_tlbelo1: rd_val = tlbelo1;
            reg_tlbcmd:  rd_val = '0;
            default: begin
                rd_val = '0;
                rd_ok  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
        end else begin
            s_arready <= s_arvalid & ~s_rvalid & ~s_arready;
            if (s_rvalid && s_rready) begin
                s_rvalid <= 1'b0;
            end
            if (rd_fire) begin
                s_rvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_fire) begin
            s_rdata <= rd_val;
            s_rresp <= rd_ok ? resp_okay : resp_slverr;
        end
    end

endmodule

//--- logic/mmu_pkg.sv
package mmu_pkg;

    localparam int tlb_num = 16;
    localparam int palen   = 32;

    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [5:0]  ps_t;

    localparam ps_t ps_4k = 6'd12;
    localparam ps_t ps_4m = 6'd21;

    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_page_t;

    typedef struct packed {
        logic      e;
        vppn_t     vppn;
        ps_t       ps;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    // lookup result, index travels separately
    typedef struct packed {
        logic      found;
        ps_t       ps;
        tlb_page_t page;
    } tlb_result_t;

    typedef enum logic [1:0] {
        acc_fetch = 2'd0,
        acc_load  = 2'd1,
        acc_store = 2'd2
    } access_t;

    // bit 5 down to bit 0
    typedef struct packed {
        logic pme;
        logic ppe;
        logic pis;
        logic pil;
        logic pif;
        logic tlbr;
    } tlb_ex_t;

endpackage

//--- logic/mmu_top.sv
`timescale 1ns/10ps

module mmu_top
    import mmu_pkg::*;
#(
    parameter int TLBNUM = tlb_num
)
(
    input  logic        aclk,
    input  logic        arst_n,
    input  logic [7:0]  s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic [3:0]  s_wstrb,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [7:0]  s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready,
    input  logic        fetch_req_valid,
    input  logic [31:0] fetch_va,
    output logic        fetch_rsp_valid,
    output logic [31:0] fetch_pa,
    output tlb_ex_t     fetch_ex,
    input  logic        data_req_valid,
    input  logic [31:0] data_va,
    input  logic        data_is_store,
    output logic        data_rsp_valid,
    output logic [31:0] data_pa,
    output tlb_ex_t     data_ex
);
    logic [31:0]               crmd;
    logic [31:0]               asid;
    logic [31:0]               dmw0;
    logic [31:0]               dmw1;
    logic                      tlb_we;
    logic [$clog2(TLBNUM)-1:0] tlb_windex;
    tlb_entry_t                tlb_wentry;
    logic                      inv_valid;
    logic [4:0]                inv_op;

    tlb_search_if #(.TLBNUM(TLBNUM)) fetch_search ();
    tlb_search_if #(.TLBNUM(TLBNUM)) data_search ();

    mmu_csr_axil #(.TLBNUM(TLBNUM)) u_csr (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .s_awaddr   (s_awaddr),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .s_wdata    (s_wdata),
        .s_wstrb    (s_wstrb),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .s_bresp    (s_bresp),
        .s_bvalid   (s_bvalid),
        .s_bready   (s_bready),
        .s_araddr   (s_araddr),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .s_rdata    (s_rdata),
        .s_rresp    (s_rresp),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .crmd       (crmd),
        .asid       (asid),
        .dmw0       (dmw0),
        .dmw1       (dmw1),
        .tlb_we     (tlb_we),
        .tlb_windex (tlb_windex),
        .tlb_wentry (tlb_wentry),
        .inv_valid  (inv_valid),
        .inv_op     (inv_op)
    );

    tlb #(.TLBNUM(TLBNUM)) u_tlb (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .s0         (fetch_search.tlb),
        .s1         (data_search.tlb),
        .tlb_we     (tlb_we),
        .tlb_windex (tlb_windex),
        .tlb_wentry (tlb_wentry),
        .inv_valid  (inv_valid),
        .inv_op     (inv_op)
    );

    addr_translate u_fetch_xlate (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .req_valid (fetch_req_valid),
        .va        (fetch_va),
        .access    (acc_fetch),
        .rsp_valid (fetch_rsp_valid),
        .pa        (fetch_pa),
        .tlb_ex    (fetch_ex),
        .crmd      (crmd),
        .asid      (asid),
        .dmw0      (dmw0),
        .dmw1      (dmw1),
        .search    (fetch_search.requester)
    );

    addr_translate u_data_xlate (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .req_valid (data_req_valid),
        .va        (data_va),
        .access    (data_is_store ? acc_store : acc_load),
        .rsp_valid (data_rsp_valid),
        .pa        (data_pa),
        .tlb_ex    (data_ex),
        .crmd      (crmd),
        .asid      (asid),
        .dmw0      (dmw0),
        .dmw1      (dmw1),
        .search    (data_search.requester)
    );

endmodule

//--- logic/tlb.sv
`timescale 1ns/10ps

module tlb
    import mmu_pkg::*;
#(
    parameter int TLBNUM = tlb_num
)
(
    input  logic                      aclk,
    input  logic                      arst_n,
    tlb_search_if.tlb                 s0,
    tlb_search_if.tlb                 s1,
    input  logic                      tlb_we,
    input  logic [$clog2(TLBNUM)-1:0] tlb_windex,
    input  tlb_entry_t                tlb_wentry,
    input  logic                      inv_valid,
    input  logic [4:0]                inv_op
);
    localparam int idx_w = $clog2(TLBNUM);

    tlb_entry_t       mem [TLBNUM];
    logic [TLBNUM-1:0] tlb_e;
    tlb_result_t      s0_res;
    tlb_result_t      s1_res;
    logic [idx_w-1:0] s0_idx;
    logic [idx_w-1:0] s1_idx;

    function automatic tlb_result_t lookup(input vppn_t vppn, input logic va_bit12,
                                           input asid_t asid, output logic [idx_w-1:0] idx);
        tlb_result_t res;
        logic        hit;
        logic        odd;
        res = '0;
        idx = '0;
        for (int i = 0; i < TLBNUM; i++) begin
            hit = tlb_e[i] && (mem[i].g || mem[i].asid == asid) &&
                  ((mem[i].ps == ps_4m) ? (mem[i].vppn[18:9] == vppn[18:9])
                                        : (mem[i].vppn == vppn));
            if (hit && !res.found) begin
                // 4M pages pick the half by vppn bit 8
                odd       = (mem[i].ps == ps_4m) ? vppn[8] : va_bit12;
                res.found = 1'b1;
                res.ps    = mem[i].ps;
                res.page  = odd ? mem[i].page1 : mem[i].page0;
                idx       = idx_w'(i);
            end
        end
        return res;
    endfunction

    always_comb begin
        s0_res = lookup(s0.vppn, s0.va_bit12, s0.asid, s0_idx);
        s1_res = lookup(s1.vppn, s1.va_bit12, s1.asid, s1_idx);
    end

    assign s0.found = s0_res.found;
    assign s0.index = s0_idx;
    assign s0.ppn   = s0_res.page.ppn;
    assign s0.ps    = s0_res.ps;
    assign s0.plv   = s0_res.page.plv;
    assign s0.mat   = s0_res.page.mat;
    assign s0.d     = s0_res.page.d;
    assign s0.v     = s0_res.page.v;

    assign s1.found = s1_res.found;
    assign s1.index = s1_idx;
    assign s1.ppn   = s1_res.page.ppn;
    assign s1.ps    = s1_res.ps;
    assign s1.plv   = s1_res.page.plv;
    assign s1.mat   = s1_res.page.mat;
    assign s1.d     = s1_res.page.d;
    assign s1.v     = s1_res.page.v;

    always_ff @(posedge aclk) begin
        if (tlb_we) begin
            mem[tlb_windex] <= tlb_wentry;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            tlb_e <= '0;
        end else begin
            if (tlb_we) begin
                tlb_e[tlb_windex] <= tlb_wentry.e;
            end
            if (inv_valid) begin
                for (int i = 0; i < TLBNUM; i++) begin
                    case (inv_op)
                        5'd0, 5'd1: tlb_e[i] <= 1'b0;
                        5'd2:       if (mem[i].g) tlb_e[i] <= 1'b0;
                        5'd3:       if (!mem[i].g) tlb_e[i] <= 1'b0;
                        default:    ;
                    endcase
                end
            end
        end
    end

endmodule

//--- logic/tlb_search_if.sv
`timescale 1ns/10ps

interface tlb_search_if
    import mmu_pkg::*;
#(
    parameter int TLBNUM = tlb_num
);
    localparam int idx_w = $clog2(TLBNUM);

    vppn_t            vppn;
    logic             va_bit12;
    asid_t            asid;
    logic             found;
    logic [idx_w-1:0] index;
    ppn_t             ppn;
    ps_t              ps;
    plv_t             plv;
    mat_t             mat;
    logic             d;
    logic             v;

    modport requester (
        output vppn, va_bit12, asid,
        input  found, index, ppn, ps, plv, mat, d, v
    );

    modport tlb (
        input  vppn, va_bit12, asid,
        output found, index, ppn, ps, plv, mat, d, v
    );

endinterface

//--- test/mmu_tb.sv
`timescale 1ns/10ps

module mmu_tb
    import mmu_pkg::*;
    import csr_pkg::*;
;
    localparam int n_rows     = 66;
    localparam int stim_delay = 2;

    typedef enum logic [2:0] {
        act_wr,
        act_rd,
        act_fetch,
        act_load,
        act_store
    } act_t;

    // arg is the write data, or the mask for the random page offset
    // flags holds bresp/rresp for bus rows
    typedef struct packed {
        act_t        act;
        logic [31:0] addr;
        logic [31:0] arg;
        logic [3:0]  strb;
        logic [31:0] exp;
        logic [5:0]  flags;
    } row_t;

    localparam logic [5:0] fl_none = 6'h00;
    localparam logic [5:0] fl_tlbr = 6'h01;
    localparam logic [5:0] fl_pif  = 6'h02;
    localparam logic [5:0] fl_pil  = 6'h04;
    localparam logic [5:0] fl_pis  = 6'h08;
    localparam logic [5:0] fl_ppe  = 6'h10;
    localparam logic [5:0] fl_pme  = 6'h20;
    localparam logic [5:0] r_ok    = 6'h0;
    localparam logic [5:0] r_err   = 6'h2;

    localparam row_t rows [n_rows] = '{
        // direct mode out of reset
        '{act_rd,    reg_crmd,     32'h0,         4'h0, 32'h0000_0008, r_ok},
        '{act_fetch, 32'h1234_5000, 32'h0000_0FFF, 4'h0, 32'h1234_5000, fl_none},
        '{act_load,  32'h8765_4000, 32'h0000_0FFF, 4'h0, 32'h8765_4000, fl_none},
        '{act_store, 32'hA000_0000, 32'h0000_FFFF, 4'h0, 32'hA000_0000, fl_none},
        // register block, byte enables and unmapped offset
        '{act_wr,    reg_asid,     32'h0000_0155, 4'hf, 32'h0,         r_ok},
        '{act_rd,    reg_asid,     32'h0,         4'h0, 32'h0000_0155, r_ok},
        '{act_wr,    reg_asid,     32'hFFFF_FFAA, 4'h1, 32'h0,         r_ok},
        '{act_rd,    reg_asid,     32'h0,         4'h0, 32'h0000_01AA, r_ok},
        '{act_wr,    32'h24,       32'hDEAD_BEEF, 4'hf, 32'h0,         r_err},
        '{act_rd,    32'h24,       32'h0,         4'h0, 32'h0,         r_err},
        '{act_rd,    reg_asid,     32'h0,         4'h0, 32'h0000_01AA, r_ok},
        '{act_rd,    reg_tlbcmd,   32'h0,         4'h0, 32'h0,         r_ok},
        // windows: dmw0 plv0 only, dmw1 plv0 and plv1
        '{act_wr,    reg_crmd,     32'h0000_0010, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_dmw0,     32'h8000_0001, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_dmw1,     32'h8200_0003, 4'hf, 32'h0,         r_ok},
        '{act_fetch, 32'h8000_0000, 32'h1FFF_FFFF, 4'h0, 32'h0000_0000, fl_none},
        '{act_store, 32'h8000_0000, 32'h1FFF_FFFF, 4'h0, 32'h0000_0000, fl_none},
        '{act_load,  32'hA000_0000, 32'h0000_0FFF, 4'h0, 32'h0,         fl_tlbr},
        '{act_wr,    reg_crmd,     32'h0000_0011, 4'hf, 32'h0,         r_ok},
        '{act_load,  32'h8000_0000, 32'h1FFF_FFFF, 4'h0, 32'h2000_0000, fl_none},
        '{act_wr,    reg_crmd,     32'h0000_0013, 4'hf, 32'h0,         r_ok},
        '{act_fetch, 32'h8000_0000, 32'h1FFF_FFFF, 4'h0, 32'h0,         fl_tlbr},
        '{act_wr,    reg_crmd,     32'h0000_0010, 4'hf, 32'h0,         r_ok},
        // entry 0: 4K pair, entry 1: 4M global, entry 2: 4K invalid
        '{act_wr,    reg_asid,     32'h0000_0001, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbidx,   32'h0C00_0000, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbehi,   32'h0040_0000, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbelo0,  32'h0123_4503, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbelo1,  32'h0234_5601, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbcmd,   32'h0000_0000, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbidx,   32'h1500_0001, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbehi,   32'h0080_0000, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbelo0,  32'h0400_004F, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbelo1,  32'h0800_004F, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbcmd,   32'h0000_0000, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbidx,   32'h0C00_0002, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbehi,   32'h0060_0000, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbelo0,  32'h0001_1100, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbelo1,  32'h0001_1100, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_tlbcmd,   32'h0000_0000, 4'hf, 32'h0,         r_ok},
        '{act_fetch, 32'h0040_0000, 32'h0000_0FFF, 4'h0, 32'h1234_5000, fl_none},
        '{act_load,  32'h0040_1000, 32'h0000_0FFF, 4'h0, 32'h2345_6000, fl_none},
        '{act_store, 32'h0040_0000, 32'h0000_0FFF, 4'h0, 32'h1234_5000, fl_none},
        '{act_store, 32'h0040_1000, 32'h0000_0FFF, 4'h0, 32'h2345_6000, fl_pme},
        '{act_fetch, 32'h0080_0000, 32'h001F_FFFF, 4'h0, 32'h4000_0000, fl_none},
        '{act_load,  32'h00A0_0000, 32'h001F_FFFF, 4'h0, 32'h8020_0000, fl_none},
        '{act_fetch, 32'h0060_0000, 32'h0000_0FFF, 4'h0, 32'h0011_1000, fl_pif},
        '{act_load,  32'h0060_1000, 32'h0000_0FFF, 4'h0, 32'h0011_1000, fl_pil},
        '{act_store, 32'h0060_0000, 32'h0000_0FFF, 4'h0, 32'h0011_1000, fl_pis},
        '{act_load,  32'h0300_0000, 32'h0000_0FFF, 4'h0, 32'h0,         fl_tlbr},
        // other asid: only the global entry still hits
        '{act_wr,    reg_asid,     32'h0000_0002, 4'hf, 32'h0,         r_ok},
        '{act_fetch, 32'h0080_0000, 32'h001F_FFFF, 4'h0, 32'h4000_0000, fl_none},
        '{act_load,  32'h0040_0000, 32'h0000_0FFF, 4'h0, 32'h0,         fl_tlbr},
        // plv3 against plv0 and plv3 pages
        '{act_wr,    reg_asid,     32'h0000_0001, 4'hf, 32'h0,         r_ok},
        '{act_wr,    reg_crmd,     32'h0000_0013, 4'hf, 32'h0,         r_ok},
        '{act_load,  32'h0040_0000, 32'h0000_0FFF, 4'h0, 32'h1234_5000, fl_ppe},
        '{act_store, 32'h0040_1000, 32'h0000_0FFF, 4'h0, 32'h2345_6000, fl_ppe},
        '{act_fetch, 32'h00A0_0000, 32'h001F_FFFF, 4'h0, 32'h8020_0000, fl_none},
        '{act_wr,    reg_crmd,     32'h0000_0010, 4'hf, 32'h0,         r_ok},
        // invtlb op 3, then op 0
        '{act_wr,    reg_tlbcmd,   32'h0000_0031, 4'hf, 32'h0,         r_ok},
        '{act_fetch, 32'h0040_0000, 32'h0000_0FFF, 4'h0, 32'h0,         fl_tlbr},
        '{act_load,  32'h0080_0000, 32'h001F_FFFF, 4'h0, 32'h4000_0000, fl_none},
        '{act_wr,    reg_tlbcmd,   32'h0000_0001, 4'hf, 32'h0,         r_ok},
        '{act_fetch, 32'h0080_0000, 32'h001F_FFFF, 4'h0, 32'h0,         fl_tlbr},
        '{act_load,  32'h00A0_0000, 32'h001F_FFFF, 4'h0, 32'h0,         fl_tlbr},
        '{act_rd,    reg_tlbidx,   32'h0,         4'h0, 32'h0C00_0002, r_ok},
        '{act_rd,    reg_crmd,     32'h0,         4'h0, 32'h0000_0010, r_ok}
    };

    logic        aclk;
    logic        arst_n;
    logic [7:0]  s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic [3:0]  s_wstrb;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [7:0]  s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;
    logic        fetch_req_valid;
    logic [31:0] fetch_va;
    logic        fetch_rsp_valid;
    logic [31:0] fetch_pa;
    tlb_ex_t     fetch_ex;
    logic        data_req_valid;
    logic [31:0] data_va;
    logic        data_is_store;
    logic        data_rsp_valid;
    logic [31:0] data_pa;
    tlb_ex_t     data_ex;

    bit          row_fail;
    int          n_fail;
    row_t        r;
    logic [31:0] off;
    logic [31:0] va;
    logic [31:0] got;
    logic [5:0]  got_ex;
    logic [1:0]  resp;

    tb_clock #(.period(40.0), .reset_cycles(4)) u_clock (
        .aclk   (aclk),
        .arst_n (arst_n)
    );

    mmu_top #(.TLBNUM(tlb_num)) u_mmu_top (.*);

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, actual, expected);
            row_fail = 1'b1;
        end
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] bresp);
        @(posedge aclk);
        #stim_delay;
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = strb;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        @(negedge aclk);
        while (!(s_awready && s_wready)) @(negedge aclk);
        @(posedge aclk);
        #stim_delay;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        @(negedge aclk);
        while (!s_bvalid) @(negedge aclk);
        bresp = s_bresp;
        @(posedge aclk);
        #stim_delay;
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] rresp);
        @(posedge aclk);
        #stim_delay;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        @(negedge aclk);
        while (!s_arready) @(negedge aclk);
        @(posedge aclk);
        #stim_delay;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        @(negedge aclk);
        while (!s_rvalid) @(negedge aclk);
        data  = s_rdata;
        rresp = s_rresp;
        @(posedge aclk);
        #stim_delay;
        s_rready = 1'b0;
    endtask

    // one request, the response is due the next cycle and only on its own port
    task automatic translate(input act_t act, input logic [31:0] addr,
                             output logic [31:0] pa, output logic [5:0] ex);
        @(posedge aclk);
        #stim_delay;
        if (act == act_fetch) begin
            fetch_va        = addr;
            fetch_req_valid = 1'b1;
        end else begin
            data_va        = addr;
            data_is_store  = (act == act_store);
            data_req_valid = 1'b1;
        end
        @(posedge aclk);
        #stim_delay;
        fetch_req_valid = 1'b0;
        data_req_valid  = 1'b0;
        @(negedge aclk);
        if (act == act_fetch) begin
            compare("fetch_rsp_valid", 32'(fetch_rsp_valid), 32'h1);
            compare("data_rsp_valid", 32'(data_rsp_valid), 32'h0);
            pa = fetch_pa;
            ex = fetch_ex;
        end else begin
            compare("data_rsp_valid", 32'(data_rsp_valid), 32'h1);
            compare("fetch_rsp_valid", 32'(fetch_rsp_valid), 32'h0);
            pa = data_pa;
            ex = data_ex;
        end
        // no request any more, so no response either
        @(negedge aclk);
        compare("fetch_rsp_valid", 32'(fetch_rsp_valid), 32'h0);
        compare("data_rsp_valid", 32'(data_rsp_valid), 32'h0);
    endtask

    initial begin
        s_awaddr        = '0;
        s_awvalid       = 1'b0;
        s_wdata         = '0;
        s_wstrb         = '0;
        s_wvalid        = 1'b0;
        s_bready        = 1'b0;
        s_araddr        = '0;
        s_arvalid       = 1'b0;
        s_rready        = 1'b0;
        fetch_req_valid = 1'b0;
        fetch_va        = '0;
        data_req_valid  = 1'b0;
        data_va         = '0;
        data_is_store   = 1'b0;
        n_fail          = 0;
        void'($urandom(97));
        wait (arst_n === 1'b1);

        for (int i = 0; i < n_rows; i++) begin
            row_fail = 1'b0;
            r        = rows[i];
            case (r.act)
                act_wr: begin
                    axi_write(r.addr[7:0], r.arg, r.strb, resp);
                    compare("s_bresp", 32'(resp), 32'(r.flags));
                end
                act_rd: begin
                    axi_read(r.addr[7:0], got, resp);
                    compare("s_rresp", 32'(resp), 32'(r.flags));
                    // data only means something on an okay response
                    if (r.flags == r_ok) begin
                        compare("s_rdata", got, r.exp);
                    end
                end
                default: begin
                    off = $urandom & r.arg;
                    va  = r.addr | off;
                    translate(r.act, va, got, got_ex);
                    if (!r.flags[0]) begin
                        compare(r.act == act_fetch ? "fetch_pa" : "data_pa", got, r.exp | off);
                    end
                    compare(r.act == act_fetch ? "fetch_ex" : "data_ex",
                            32'(got_ex), 32'(r.flags));
                end
            endcase
            if (row_fail) begin
                n_fail++;
            end
            $display("test %0d %s addr 0x%08h: %s", i, r.act.name(), r.addr,
                     row_fail ? "mismatch" : "ok");
        end

        $display("%0d tests run, %0d failed", n_rows, n_fail);
        if (n_fail == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // a row needs well under 20 cycles
    initial begin
        repeat (n_rows * 20) @(posedge aclk);
        $display("timeout: the tests did not finish within %0d clock cycles", n_rows * 20);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter real period       = 40.0,
    parameter int  reset_cycles = 4
)
(
    output logic aclk,
    output logic arst_n
);
    initial begin
        aclk = 1'b0;
        forever #(period / 2.0) aclk = ~aclk;
    end

    // release a little after the edge, like the other inputs
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge aclk);
        #2;
        arst_n = 1'b1;
    end

endmodule
